/* src/cdc_fifo_pkg.sv */
// ######################################################################
// clearable dual-clock FIFO package
// shared widths, FIFO depth, synchronizer depth, payload and pointer
// types, the clear sequencer states and the Gray-code helpers
// ######################################################################

package cdc_fifo_pkg;

  // payload word and storage geometry
  localparam int unsigned DATA_WIDTH  = 16;
  localparam int unsigned LOG_DEPTH   = 3;
  localparam int unsigned DEPTH       = 2 ** LOG_DEPTH;
  // one extra pointer bit tells a full FIFO apart from an empty one
  localparam int unsigned PTR_WIDTH   = LOG_DEPTH + 1;
  localparam int unsigned SYNC_STAGES = 3;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [PTR_WIDTH-1:0]  ptr_t;

  // phases of the lock-step clear sequence, identical in both domains
  typedef enum logic [1:0] {
    CLR_IDLE,
    CLR_ISOLATE,
    CLR_CLEAR,
    CLR_RELEASE
  } clear_state_e;

  // adjacent binary values map to Gray codes that differ in one bit
  function automatic ptr_t bin_to_gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // each binary bit is the XOR of all Gray bits at or above it
  function automatic ptr_t gray_to_binary(input ptr_t gray);
    ptr_t bin;
    bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
    for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* src/cdc_clear_if.sv */
// ######################################################################
// clear handshake bundle of one clock domain
// the sequencer raises isolate and clear requests, the top level
// answers each with a registered acknowledge
// ######################################################################

`timescale 1ns/1ps

interface cdc_clear_if;

  logic clear_req;
  logic clear_ack;
  logic isolate_req;
  logic isolate_ack;

  // the sequencer side owns both requests
  modport ctrl (
    output clear_req,
    output isolate_req,
    input  clear_ack,
    input  isolate_ack
  );

  // the acknowledge side follows each request one cycle later
  modport ack_gen (
    input  clear_req,
    input  isolate_req,
    output clear_ack,
    output isolate_ack
  );

endinterface

/* src/cdc_sync.sv */
// ######################################################################
// multi-bit flip-flop synchronizer
// moves a vector into the clock domain of clk_i through a chain of
// SYNC_STAGES registers that all reset to zero
// ######################################################################

`timescale 1ns/1ps

module cdc_sync #(
  parameter int unsigned WIDTH = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [WIDTH-1:0] d_i,
  output logic [WIDTH-1:0] q_o
);

  import cdc_fifo_pkg::*;

  // stage 0 may go metastable, the later stages give it time to settle
  logic [WIDTH-1:0] stage_q [SYNC_STAGES];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d_i;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[SYNC_STAGES-1];

endmodule

/* src/cdc_fifo_src.sv */
// ######################################################################
// source half of the dual-clock FIFO
// owns the word storage and the Gray write pointer, and compares the
// write pointer against the synchronized read pointer to flag full
// ######################################################################

`timescale 1ns/1ps

module cdc_fifo_src (
  input  logic                                         src_clk_i,
  input  logic                                         src_rst_ni,
  input  logic                                         clear_i,
  input  logic                                         valid_i,
  input  cdc_fifo_pkg::data_t                          data_i,
  output logic                                         ready_o,
  output cdc_fifo_pkg::data_t [cdc_fifo_pkg::DEPTH-1:0] async_data_o,
  output cdc_fifo_pkg::ptr_t                           async_wptr_o,
  input  cdc_fifo_pkg::ptr_t                           async_rptr_i
);

  import cdc_fifo_pkg::*;

  data_t [DEPTH-1:0] mem_q;
  ptr_t              wptr_q;
  ptr_t              wptr_bin;
  ptr_t              rptr_sync;
  ptr_t              rptr_bin;
  logic              push;

  // the read pointer lags the destination by the synchronizer depth
  // so the full flag is pessimistic and the FIFO cannot overflow
  cdc_sync #(
    .WIDTH (PTR_WIDTH)
  ) u_rptr_sync (
    .clk_i  (src_clk_i),
    .rst_ni (src_rst_ni),
    .d_i    (async_rptr_i),
    .q_o    (rptr_sync)
  );

  assign rptr_bin = gray_to_binary(rptr_sync);
  assign wptr_bin = gray_to_binary(wptr_q);

  // full when the addresses match but the wrap bits differ
  assign ready_o = (wptr_bin ^ rptr_bin) != ptr_t'(DEPTH);
  assign push    = valid_i & ready_o;

  // storage is only ever written in this domain
  always_ff @(posedge src_clk_i) begin
    if (push) begin
      mem_q[wptr_bin[LOG_DEPTH-1:0]] <= data_i;
    end
  end

  // the pointer advances one Gray step per word, so the destination
  // never samples more than one changing bit
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      wptr_q <= '0;
    end else if (clear_i) begin
      wptr_q <= '0;
    end else if (push) begin
      wptr_q <= bin_to_gray(wptr_bin + ptr_t'(1));
    end
  end

  // the whole array is visible to the destination read select
  assign async_data_o = mem_q;
  assign async_wptr_o = wptr_q;

endmodule

/* src/cdc_fifo_dst.sv */
// ######################################################################
// destination half of the dual-clock FIFO
// owns the Gray read pointer, detects not-empty against the
// synchronized write pointer and hands words to a flushable one-entry
// spill register that decouples ready_i from the FIFO
// ######################################################################

`timescale 1ns/1ps

module cdc_fifo_dst (
  input  logic                                         dst_clk_i,
  input  logic                                         dst_rst_ni,
  input  logic                                         clear_i,
  input  logic                                         ready_i,
  input  cdc_fifo_pkg::data_t [cdc_fifo_pkg::DEPTH-1:0] async_data_i,
  input  cdc_fifo_pkg::ptr_t                           async_wptr_i,
  output logic                                         valid_o,
  output cdc_fifo_pkg::data_t                          data_o,
  output cdc_fifo_pkg::ptr_t                           async_rptr_o
);

  import cdc_fifo_pkg::*;

  ptr_t  rptr_q;
  ptr_t  rptr_bin;
  ptr_t  wptr_sync;
  data_t rd_data;
  logic  fifo_valid;
  logic  take;
  data_t spill_q;
  logic  spill_full_q;

  // the write pointer is seen late, so a word counted here was
  // written to storage several source cycles ago and is stable
  cdc_sync #(
    .WIDTH (PTR_WIDTH)
  ) u_wptr_sync (
    .clk_i  (dst_clk_i),
    .rst_ni (dst_rst_ni),
    .d_i    (async_wptr_i),
    .q_o    (wptr_sync)
  );

  assign rptr_bin = gray_to_binary(rptr_q);

  // equal Gray pointers mean empty, no conversion needed for this
  assign fifo_valid = (wptr_sync != rptr_q);

  // read select, clocked entirely by the destination domain
  assign rd_data = async_data_i[rptr_bin[LOG_DEPTH-1:0]];

  // the spill register only loads while empty, which keeps ready_i out
  // of the read pointer logic
  // no load during a clear, the pointers may still be settling then
  assign take = fifo_valid & ~spill_full_q & ~clear_i;

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      rptr_q <= '0;
    end else if (clear_i) begin
      rptr_q <= '0;
    end else if (take) begin
      rptr_q <= bin_to_gray(rptr_bin + ptr_t'(1));
    end
  end

  // occupancy of the spill entry
  // a clear drops whatever word it holds
  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      spill_full_q <= 1'b0;
    end else if (clear_i) begin
      spill_full_q <= 1'b0;
    end else if (take) begin
      spill_full_q <= 1'b1;
    end else if (ready_i) begin
      spill_full_q <= 1'b0;
    end
  end

  // payload only changes on a load, so data_o holds under back-pressure
  always_ff @(posedge dst_clk_i) begin
    if (take) begin
      spill_q <= rd_data;
    end
  end

  assign valid_o      = spill_full_q;
  assign data_o       = spill_q;
  assign async_rptr_o = rptr_q;

endmodule

/* src/cdc_clear_ctrl.sv */
// ######################################################################
// two-domain clear sequencer
// walks both domains through isolate, clear and release in lock-step
// the source machine leads each phase over a four-phase pair toward
// the destination, and a second pair lets the destination ask the
// source to start a sequence
// ######################################################################

`timescale 1ns/1ps

module cdc_clear_ctrl (
  input  logic            src_clk_i,
  input  logic            src_rst_ni,
  input  logic            src_clear_i,
  cdc_clear_if.ctrl       src_if,
  input  logic            dst_clk_i,
  input  logic            dst_rst_ni,
  input  logic            dst_clear_i,
  cdc_clear_if.ctrl       dst_if
);

  import cdc_fifo_pkg::*;

  clear_state_e src_state_q;
  clear_state_e dst_state_q;
  // phase pair from source to destination
  logic         s2d_req_q;
  logic         s2d_ack_q;
  // start pair from destination to source
  logic         d2s_req_q;
  logic         d2s_ack_q;
  // synchronized copies, the first two live in the source domain
  logic         s2d_ack_sync;
  logic         d2s_req_sync;
  logic         s2d_req_sync;
  logic         d2s_ack_sync;
  logic         src_local_ack;
  logic         src_start;
  logic         dst_local_ack;
  logic         dst_join;
  logic         dst_start;
  logic         dst_got_q;
  logic         dst_start_q;

  cdc_sync #(
    .WIDTH (2)
  ) u_to_src_sync (
    .clk_i  (src_clk_i),
    .rst_ni (src_rst_ni),
    .d_i    ({s2d_ack_q, d2s_req_q}),
    .q_o    ({s2d_ack_sync, d2s_req_sync})
  );

  cdc_sync #(
    .WIDTH (2)
  ) u_to_dst_sync (
    .clk_i  (dst_clk_i),
    .rst_ni (dst_rst_ni),
    .d_i    ({s2d_req_q, d2s_ack_q}),
    .q_o    ({s2d_req_sync, d2s_ack_sync})
  );

  // a phase is locally done once the top level has answered it
  always_comb begin
    case (src_state_q)
      CLR_ISOLATE: src_local_ack = src_if.isolate_ack;
      CLR_CLEAR:   src_local_ack = src_if.clear_ack;
      default:     src_local_ack = 1'b1;
    endcase
  end

  always_comb begin
    case (dst_state_q)
      CLR_ISOLATE: dst_local_ack = dst_if.isolate_ack;
      CLR_CLEAR:   dst_local_ack = dst_if.clear_ack;
      default:     dst_local_ack = 1'b1;
    endcase
  end

  // isolation covers the whole sequence, clear only its middle phase
  assign src_if.isolate_req = (src_state_q != CLR_IDLE);
  assign src_if.clear_req   = (src_state_q == CLR_CLEAR);
  // the destination isolates at once while its start request travels
  assign dst_if.isolate_req = (dst_state_q != CLR_IDLE) | dst_start_q;
  assign dst_if.clear_req   = (dst_state_q == CLR_CLEAR);

  // a new destination request is one the source has not answered yet
  assign src_start = src_clear_i | (d2s_req_sync & ~d2s_ack_q);

  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      src_state_q <= CLR_IDLE;
      s2d_req_q   <= 1'b0;
      d2s_ack_q   <= 1'b0;
    end else begin
      // answer a start request only while nothing has been cleared yet,
      // later ones wait and then get a sequence of their own
      if (!d2s_req_sync) begin
        d2s_ack_q <= 1'b0;
      end else if (src_state_q == CLR_IDLE || src_state_q == CLR_ISOLATE) begin
        d2s_ack_q <= 1'b1;
      end
      if (src_state_q == CLR_IDLE) begin
        if (src_start) begin
          src_state_q <= CLR_ISOLATE;
        end
      end else if (s2d_req_q) begin
        // the partner has entered the same phase, move on
        if (s2d_ack_sync) begin
          s2d_req_q <= 1'b0;
          case (src_state_q)
            CLR_ISOLATE: src_state_q <= CLR_CLEAR;
            CLR_CLEAR:   src_state_q <= CLR_RELEASE;
            default:     src_state_q <= CLR_IDLE;
          endcase
        end
      end else if (!s2d_ack_sync && src_local_ack) begin
        // the previous exchange has returned to zero and our own step
        // is done, so pull the partner into this phase
        s2d_req_q <= 1'b1;
      end
    end
  end

  // every fresh phase request moves the destination one phase ahead
  assign dst_join  = s2d_req_sync & ~s2d_ack_q & ~dst_got_q;
  assign dst_start = dst_clear_i & (dst_state_q == CLR_IDLE) & ~dst_start_q & ~dst_join;

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      dst_state_q <= CLR_IDLE;
      dst_got_q   <= 1'b0;
      dst_start_q <= 1'b0;
      s2d_ack_q   <= 1'b0;
      d2s_req_q   <= 1'b0;
    end else begin
      if (dst_join) begin
        dst_got_q   <= 1'b1;
        dst_start_q <= 1'b0;
        case (dst_state_q)
          CLR_IDLE:    dst_state_q <= CLR_ISOLATE;
          CLR_ISOLATE: dst_state_q <= CLR_CLEAR;
          default:     dst_state_q <= CLR_RELEASE;
        endcase
      end else if (dst_got_q && dst_local_ack) begin
        // our step of the phase is done, report it to the source
        dst_got_q <= 1'b0;
        s2d_ack_q <= 1'b1;
      end else if (s2d_ack_q && !s2d_req_sync) begin
        // the release exchange closing out ends the sequence here
        s2d_ack_q <= 1'b0;
        if (dst_state_q == CLR_RELEASE) begin
          dst_state_q <= CLR_IDLE;
        end
      end else if (dst_start) begin
        dst_start_q <= 1'b1;
      end
      if (dst_start) begin
        d2s_req_q <= 1'b1;
      end else if (d2s_ack_sync) begin
        d2s_req_q <= 1'b0;
      end
    end
  end

endmodule

/* src/cdc_fifo_clearable.sv */
// ######################################################################
// clearable dual-clock FIFO, top level
// joins the source and destination halves with the clear sequencer,
// masks the handshakes while a domain is isolated and answers the
// sequencer requests with registered acknowledges
// ######################################################################

`timescale 1ns/1ps

module cdc_fifo_clearable (
  input  logic                src_clk_i,
  input  logic                src_rst_ni,
  input  logic                src_clear_i,
  input  logic                src_valid_i,
  input  cdc_fifo_pkg::data_t src_data_i,
  output logic                src_ready_o,
  output logic                src_clear_pending_o,
  input  logic                dst_clk_i,
  input  logic                dst_rst_ni,
  input  logic                dst_clear_i,
  input  logic                dst_ready_i,
  output logic                dst_valid_o,
  output cdc_fifo_pkg::data_t dst_data_o,
  output logic                dst_clear_pending_o
);

  import cdc_fifo_pkg::*;

  // these three bundles are the only paths across the boundary
  data_t [DEPTH-1:0] async_data;
  ptr_t              async_wptr;
  ptr_t              async_rptr;
  logic              src_ready;
  logic              dst_valid;

  cdc_clear_if src_clr_if ();
  cdc_clear_if dst_clr_if ();

  // an isolated side neither accepts nor offers words
  cdc_fifo_src u_src (
    .src_clk_i    (src_clk_i),
    .src_rst_ni   (src_rst_ni),
    .clear_i      (src_clr_if.clear_req),
    .valid_i      (src_valid_i & ~src_clr_if.isolate_req),
    .data_i       (src_data_i),
    .ready_o      (src_ready),
    .async_data_o (async_data),
    .async_wptr_o (async_wptr),
    .async_rptr_i (async_rptr)
  );

  assign src_ready_o = src_ready & ~src_clr_if.isolate_req;

  cdc_fifo_dst u_dst (
    .dst_clk_i    (dst_clk_i),
    .dst_rst_ni   (dst_rst_ni),
    .clear_i      (dst_clr_if.clear_req),
    .ready_i      (dst_ready_i & ~dst_clr_if.isolate_req),
    .async_data_i (async_data),
    .async_wptr_i (async_wptr),
    .valid_o      (dst_valid),
    .data_o       (dst_data_o),
    .async_rptr_o (async_rptr)
  );

  assign dst_valid_o = dst_valid & ~dst_clr_if.isolate_req;

  cdc_clear_ctrl u_clear_ctrl (
    .src_clk_i   (src_clk_i),
    .src_rst_ni  (src_rst_ni),
    .src_clear_i (src_clear_i),
    .src_if      (src_clr_if),
    .dst_clk_i   (dst_clk_i),
    .dst_rst_ni  (dst_rst_ni),
    .dst_clear_i (dst_clear_i),
    .dst_if      (dst_clr_if)
  );

  // masking valid and ready isolates a side within one cycle, and a
  // clear acts on the first edge, so a one-cycle delay suffices as ack
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      src_clr_if.isolate_ack <= 1'b0;
      src_clr_if.clear_ack   <= 1'b0;
    end else begin
      src_clr_if.isolate_ack <= src_clr_if.isolate_req;
      src_clr_if.clear_ack   <= src_clr_if.clear_req;
    end
  end

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      dst_clr_if.isolate_ack <= 1'b0;
      dst_clr_if.clear_ack   <= 1'b0;
    end else begin
      dst_clr_if.isolate_ack <= dst_clr_if.isolate_req;
      dst_clr_if.clear_ack   <= dst_clr_if.clear_req;
    end
  end

  // isolation spans the whole sequence in each domain
  assign src_clear_pending_o = src_clr_if.isolate_req;
  assign dst_clear_pending_o = dst_clr_if.isolate_req;

endmodule

/* dv/tb_cdc_fifo.sv */
// ######################################################################
// testbench for the clearable dual-clock FIFO
// applies a table of transfer, back-pressure and clear scenarios and
// checks every delivered word against a scoreboard of accepted words
// ######################################################################

`timescale 1ns/1ps

module tb_cdc_fifo;

  import cdc_fifo_pkg::*;

  localparam int unsigned NUM_ROWS    = 5;
  localparam int unsigned TIMEOUT     = 2000;
  localparam int unsigned FILL_CYCLES = 60;
  // side that pulses its clear input
  localparam int unsigned NO_CLEAR    = 0;
  localparam int unsigned SRC_CLEAR   = 1;
  localparam int unsigned DST_CLEAR   = 2;

  // a stall of 100 percent selects the fill-first flow
  typedef struct packed {
    int unsigned words;
    int unsigned idle_pct;
    int unsigned stall_pct;
    int unsigned side;
    int unsigned point;
  } test_row_t;

  logic  src_clk_i = 1'b0;
  logic  dst_clk_i = 1'b0;
  logic  src_rst_ni;
  logic  dst_rst_ni;
  logic  src_clear_i;
  logic  src_valid_i;
  data_t src_data_i;
  logic  src_ready_o;
  logic  src_clear_pending_o;
  logic  dst_clear_i;
  logic  dst_ready_i;
  logic  dst_valid_o;
  data_t dst_data_o;
  logic  dst_clear_pending_o;

  test_row_t   tests [NUM_ROWS];
  // only the source monitor pushes, the destination walks it by index
  data_t       sb_q [$];
  int          rd_idx         = 0;
  int          stale_end      = 0;
  int          src_clears     = 0;
  int          dst_clears     = 0;
  int          dst_clear_reqs = 0;
  int          src_err        = 0;
  int          dst_err        = 0;
  int          main_err       = 0;
  int          tests_failed   = 0;
  int unsigned stall_pct      = 0;
  int unsigned serial         = 0;
  logic        timed_out      = 1'b0;
  logic        src_pend_q     = 1'b0;
  logic        in_clear       = 1'b0;
  logic        hold_q         = 1'b0;
  data_t       hold_data;

  always #5.5 src_clk_i = ~src_clk_i;
  always #4 dst_clk_i = ~dst_clk_i;

  cdc_fifo_clearable dut0 (
    .src_clk_i           (src_clk_i),
    .src_rst_ni          (src_rst_ni),
    .src_clear_i         (src_clear_i),
    .src_valid_i         (src_valid_i),
    .src_data_i          (src_data_i),
    .src_ready_o         (src_ready_o),
    .src_clear_pending_o (src_clear_pending_o),
    .dst_clk_i           (dst_clk_i),
    .dst_rst_ni          (dst_rst_ni),
    .dst_clear_i         (dst_clear_i),
    .dst_ready_i         (dst_ready_i),
    .dst_valid_o         (dst_valid_o),
    .dst_data_o          (dst_data_o),
    .dst_clear_pending_o (dst_clear_pending_o)
  );

  function automatic bit bit_ok(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("Error %s expected %h got %h", name, exp, got);
    end
    return got === exp;
  endfunction

  function automatic int total_errors();
    return src_err + dst_err + main_err;
  endfunction

  // the low bits count up, so every word of the run is unique
  function automatic data_t next_word();
    serial++;
    return {4'($urandom), 12'(serial)};
  endfunction

  task automatic report_timeout(input string what);
    if (!timed_out) begin
      $display("timeout while %s", what);
    end
    timed_out = 1'b1;
  endtask

  // a source clear is dropped again by the caller on the next edge
  task automatic request_clear(input int unsigned side);
    if (side == SRC_CLEAR) begin
      src_clear_i <= 1'b1;
    end else if (side == DST_CLEAR) begin
      dst_clear_reqs++;
    end
  endtask

  // offers n words with random idles and holds each until accepted
  task automatic send_burst(input int unsigned n, input int unsigned idle_pct,
                            input int unsigned side, input int unsigned clear_at);
    int unsigned sent;
    int unsigned waited;
    logic        busy;
    logic        fired;
    sent   = 0;
    waited = 0;
    busy   = 1'b0;
    fired  = 1'b0;
    while (sent < n && !timed_out) begin
      @(posedge src_clk_i);
      src_clear_i <= 1'b0;
      if (src_valid_i && src_ready_o) begin
        sent++;
        waited = 0;
        busy   = 1'b0;
      end else if (busy) begin
        waited++;
        if (waited > TIMEOUT) begin
          report_timeout("waiting for src_ready_o");
        end
      end
      if (side != NO_CLEAR && !fired && sent == clear_at) begin
        request_clear(side);
        fired = 1'b1;
      end
      if (!busy) begin
        src_valid_i <= 1'b0;
        if (sent < n && ($urandom % 100) >= idle_pct) begin
          src_valid_i <= 1'b1;
          src_data_i  <= next_word();
          busy = 1'b1;
        end
      end
    end
    src_valid_i <= 1'b0;
    @(posedge src_clk_i);
    src_clear_i <= 1'b0;
  endtask

  // with the destination stalled the FIFO and the spill entry fill up
  task automatic fill_fifo();
    int unsigned acc;
    acc = 0;
    @(posedge src_clk_i);
    src_valid_i <= 1'b1;
    src_data_i  <= next_word();
    repeat (FILL_CYCLES) begin
      @(posedge src_clk_i);
      if (src_valid_i && src_ready_o) begin
        acc++;
        src_data_i <= next_word();
      end
    end
    src_valid_i <= 1'b0;
    assert (acc == DEPTH + 1) else begin
      $display("Error src_ready_o handshakes expected %h got %h", DEPTH + 1, acc);
      main_err++;
    end
    if (!bit_ok("dst_valid_o", dst_valid_o, 1'b1)) begin
      main_err++;
    end
  endtask

  // both pending outputs must have risen, and the destination one fallen
  task automatic wait_clear_done(input int src0, input int dst0);
    int unsigned n;
    n = 0;
    while ((src_clears <= src0 || dst_clears <= dst0) && !timed_out) begin
      @(posedge dst_clk_i);
      n++;
      if (n > TIMEOUT) begin
        report_timeout("waiting for the clear sequence to finish");
      end
    end
  endtask

  task automatic wait_drain();
    int unsigned n;
    n = 0;
    while (rd_idx < sb_q.size() && !timed_out) begin
      @(posedge dst_clk_i);
      n++;
      if (n > TIMEOUT) begin
        report_timeout("waiting for the FIFO to drain");
      end
    end
  endtask

  task automatic check_after_clear();
    @(posedge src_clk_i);
    if (!bit_ok("src_ready_o", src_ready_o, 1'b1)) begin
      main_err++;
    end
    if (!bit_ok("dst_valid_o", dst_valid_o, 1'b0)) begin
      main_err++;
    end
  endtask

  task automatic report_test(input int idx, input int err0);
    if (total_errors() == err0 && !timed_out) begin
      $display("test %0d: ok", idx);
    end else begin
      $display("test %0d: %0d errors", idx, total_errors() - err0);
      tests_failed++;
    end
  endtask

  // destination driver, random stalls and clear pulses on request
  initial begin
    int clr_seen;
    clr_seen    = 0;
    dst_ready_i = 1'b0;
    dst_clear_i = 1'b0;
    forever begin
      @(posedge dst_clk_i);
      dst_ready_i <= ($urandom % 100) >= stall_pct;
      dst_clear_i <= 1'b0;
      if (clr_seen != dst_clear_reqs) begin
        clr_seen = dst_clear_reqs;
        dst_clear_i <= 1'b1;
      end
    end
  end

  // source monitor, records accepted words and the stale boundary
  always @(posedge src_clk_i) begin
    if (src_rst_ni) begin
      if (src_valid_i && src_ready_o) begin
        sb_q.push_back(src_data_i);
      end
      // nothing is accepted while pending, so every queued word is old
      if (src_clear_pending_o) begin
        stale_end = sb_q.size();
        if (!bit_ok("src_ready_o", src_ready_o, 1'b0)) begin
          src_err++;
        end
      end
      if (src_clear_pending_o && !src_pend_q) begin
        src_clears++;
      end
      src_pend_q = src_clear_pending_o;
    end
  end

  // destination monitor, words seen during a clear must be a prefix
  always @(posedge dst_clk_i) begin
    if (dst_rst_ni) begin
      if (dst_clear_pending_o) begin
        in_clear = 1'b1;
        if (!bit_ok("dst_valid_o", dst_valid_o, 1'b0)) begin
          dst_err++;
        end
      end else if (in_clear) begin
        // the words left behind by the clear are gone for good
        in_clear = 1'b0;
        if (rd_idx < stale_end) begin
          rd_idx = stale_end;
        end
        dst_clears++;
      end
      if (hold_q && dst_valid_o) begin
        assert (dst_data_o === hold_data) else begin
          $display("Error dst_data_o changed under back-pressure, expected %h got %h",
                   hold_data, dst_data_o);
          dst_err++;
        end
      end
      if (dst_valid_o && dst_ready_i) begin
        if (rd_idx >= sb_q.size()) begin
          $display("word %h left the FIFO with nothing outstanding", dst_data_o);
          dst_err++;
        end else begin
          assert (dst_data_o === sb_q[rd_idx]) else begin
            $display("Error dst_data_o expected %h got %h", sb_q[rd_idx], dst_data_o);
            dst_err++;
          end
          rd_idx++;
        end
      end
      hold_q    = dst_valid_o && !dst_ready_i;
      hold_data = dst_data_o;
    end
  end

  initial begin
    int err0;
    int src0;
    int dst0;
    int unsigned n;
    void'($urandom(97));
    src_rst_ni  = 1'b0;
    dst_rst_ni  = 1'b0;
    src_clear_i = 1'b0;
    src_valid_i = 1'b0;
    src_data_i  = '0;
    // words, idle %, stall %, clear side, clear after this many words
    tests[0] = '{64, 30, 30, NO_CLEAR, 0};
    tests[1] = '{16, 0, 100, NO_CLEAR, 0};
    tests[2] = '{48, 20, 20, SRC_CLEAR, 20};
    tests[3] = '{48, 20, 20, DST_CLEAR, 20};
    tests[4] = '{16, 0, 100, SRC_CLEAR, 0};

    repeat (8) @(posedge dst_clk_i);
    src_rst_ni <= 1'b1;
    dst_rst_ni <= 1'b1;

    // test 0 covers the state right after reset
    err0 = total_errors();
    n    = 0;
    @(posedge src_clk_i);
    while (!src_ready_o && !timed_out) begin
      @(posedge src_clk_i);
      n++;
      if (n > TIMEOUT) begin
        report_timeout("waiting for src_ready_o after reset");
      end
    end
    if (!bit_ok("src_ready_o", src_ready_o, 1'b1)) main_err++;
    if (!bit_ok("dst_valid_o", dst_valid_o, 1'b0)) main_err++;
    if (!bit_ok("src_clear_pending_o", src_clear_pending_o, 1'b0)) main_err++;
    if (!bit_ok("dst_clear_pending_o", dst_clear_pending_o, 1'b0)) main_err++;
    report_test(0, err0);

    for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
      err0      = total_errors();
      src0      = src_clears;
      dst0      = dst_clears;
      stall_pct = tests[i].stall_pct;
      if (tests[i].stall_pct == 100) begin
        fill_fifo();
        if (tests[i].side != NO_CLEAR) begin
          @(posedge src_clk_i);
          request_clear(tests[i].side);
          @(posedge src_clk_i);
          src_clear_i <= 1'b0;
          wait_clear_done(src0, dst0);
          check_after_clear();
        end
        stall_pct = 0;
        wait_drain();
        send_burst(tests[i].words, tests[i].idle_pct, NO_CLEAR, 0);
      end else begin
        send_burst(tests[i].words, tests[i].idle_pct, tests[i].side, tests[i].point);
        if (tests[i].side != NO_CLEAR) begin
          wait_clear_done(src0, dst0);
        end
      end
      wait_drain();
      report_test(i + 1, err0);
    end

    $display("%0d tests run, %0d failed, %0d errors", NUM_ROWS + 1, tests_failed,
             total_errors());
    if (total_errors() == 0 && tests_failed == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
src/cdc_fifo_pkg.sv
src/cdc_clear_if.sv
src/cdc_sync.sv
src/cdc_fifo_src.sv
src/cdc_fifo_dst.sv
src/cdc_clear_ctrl.sv
src/cdc_fifo_clearable.sv
dv/tb_cdc_fifo.sv

/* run.sh */
#!/bin/sh
# builds the clearable dual-clock FIFO testbench with Verilator and runs it
# the log is searched for the pass line to decide the result
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_cdc_fifo -f all.f

./obj_dir/Vtb_cdc_fifo > sim.log 2>&1
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi
